// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cic_decimator
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+design
design/cic_pkg.sv
design/cic_ram_if.sv
design/cic_integ_chain.sv
design/cic_comb_ram.sv
design/cic_comb_seq.sv
design/cic_decimator.sv
testbench/tb_cic_decimator.sv

// ==== design/cic_comb_ram.sv ====
`timescale 1ns/1ps
`include "cic_defines.svh"

// comb and previous values for both banks
// word layout by address {bank, kind, stage}
module cic_comb_ram (
	input logic clock,
	cic_ram_if.ram ram
);

	localparam int DEPTH = 2 ** `CIC_ADDR_WIDTH;

	cic_pkg::acc_t mem [DEPTH];

	// ------------------------------
	// ports
	// ------------------------------

	always_ff @(posedge clock)
	begin
		// write lands at this edge
		if (ram.wen)
			mem[ram.waddr] <= ram.wdata;

		// registered read, same-address write returns old word
		ram.rdata <= mem[ram.raddr];
	end

endmodule

// ==== design/cic_comb_seq.sv ====
`timescale 1ns/1ps
`include "cic_defines.svh"

// sequential comb cascade, one stage every three clocks
// comb words are written and read back in the write bank,
// prev words come from the read bank and go to the write bank
module cic_comb_seq (
	input logic clock,
	input logic rst_n,
	input logic integ_strobe,
	input cic_pkg::acc_t integ_data,
	cic_ram_if.engine ram,
	output logic out_strobe,
	output cic_pkg::out_t out_data
);

	// address kind bit
	localparam logic KIND_COMB = 1'b0;
	localparam logic KIND_PREV = 1'b1;

	localparam cic_pkg::stage_t FIRST_STAGE = cic_pkg::stage_t'(0);
	localparam cic_pkg::stage_t LAST_STAGE = cic_pkg::stage_t'(`CIC_STAGES);

	cic_pkg::comb_state_t state;
	cic_pkg::stage_t stage;

	// ping-pong select
	logic bank;
	logic rd_bank;
	logic wr_bank;

	// comb output of the stage below
	cic_pkg::acc_t below;

	// rounding bit just under the kept msbs
	logic round_bit;

	assign rd_bank = bank;
	assign wr_bank = ~bank;
	assign round_bit = ram.rdata[`CIC_ACC_WIDTH-1-`CIC_OUT_WIDTH];

	// ------------------------------
	// state and counters
	// ------------------------------

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= cic_pkg::ST_CLEAR;
			stage <= FIRST_STAGE;
			bank <= 1'b0;
			out_strobe <= 1'b0;
		end
		else
		begin
			out_strobe <= 1'b0;
			case (state)
				cic_pkg::ST_CLEAR:
				begin
					// sweep prev[0..STAGES] of the first read bank
					if (stage == LAST_STAGE)
						state <= cic_pkg::ST_IDLE;
					else
						stage <= stage + cic_pkg::stage_t'(1);
				end
				cic_pkg::ST_IDLE:
				begin
					if (integ_strobe)
					begin
						stage <= cic_pkg::stage_t'(1);
						state <= cic_pkg::ST_LOAD;
					end
				end
				cic_pkg::ST_LOAD:
					state <= cic_pkg::ST_DIFF;
				cic_pkg::ST_DIFF:
					state <= cic_pkg::ST_SAVE;
				cic_pkg::ST_SAVE:
				begin
					if (stage == LAST_STAGE)
						state <= cic_pkg::ST_TAIL;
					else
					begin
						stage <= stage + cic_pkg::stage_t'(1);
						state <= cic_pkg::ST_LOAD;
					end
				end
				cic_pkg::ST_TAIL:
					state <= cic_pkg::ST_OUT;
				cic_pkg::ST_OUT:
				begin
					out_strobe <= 1'b1;
					bank <= ~bank;
					state <= cic_pkg::ST_IDLE;
				end
				default:
					state <= cic_pkg::ST_IDLE;
			endcase
		end
	end

	// ------------------------------
	// datapath registers
	// ------------------------------

	always_ff @(posedge clock)
	begin
		// comb[stage-1] arrives during DIFF
		if (state == cic_pkg::ST_DIFF)
			below <= ram.rdata;

		// comb[STAGES] arrives during OUT, keep top bits and round
		if (state == cic_pkg::ST_OUT)
			out_data <= ram.rdata[`CIC_ACC_WIDTH-1 -: `CIC_OUT_WIDTH]
				+ {{(`CIC_OUT_WIDTH-1){1'b0}}, round_bit};
	end

	// ------------------------------
	// RAM port control
	// ------------------------------

	always_comb
	begin
		ram.wen = 1'b0;
		ram.waddr = {wr_bank, KIND_COMB, stage};
		ram.wdata = '0;
		ram.raddr = {wr_bank, KIND_COMB, stage - cic_pkg::stage_t'(1)};
		case (state)
			cic_pkg::ST_CLEAR:
			begin
				ram.wen = 1'b1;
				ram.waddr = {rd_bank, KIND_PREV, stage};
			end
			cic_pkg::ST_IDLE:
			begin
				// comb[0] is the decimated integrator value
				ram.wen = integ_strobe;
				ram.waddr = {wr_bank, KIND_COMB, FIRST_STAGE};
				ram.wdata = integ_data;
			end
			cic_pkg::ST_LOAD:
				// fetch comb[stage-1], written on an earlier edge
				ram.raddr = {wr_bank, KIND_COMB, stage - cic_pkg::stage_t'(1)};
			cic_pkg::ST_DIFF:
			begin
				// comb below becomes the new prev, old prev fetched
				ram.wen = 1'b1;
				ram.waddr = {wr_bank, KIND_PREV, stage};
				ram.wdata = ram.rdata;
				ram.raddr = {rd_bank, KIND_PREV, stage};
			end
			cic_pkg::ST_SAVE:
			begin
				// comb[stage] = comb[stage-1] - prev[stage]
				ram.wen = 1'b1;
				ram.waddr = {wr_bank, KIND_COMB, stage};
				ram.wdata = below - ram.rdata;
			end
			cic_pkg::ST_TAIL:
				ram.raddr = {wr_bank, KIND_COMB, LAST_STAGE};
			default:
				ram.wen = 1'b0;
		endcase
	end

	// decimated samples only while the engine is free
	a_strobe_in_idle: assert property (@(posedge clock) disable iff (!rst_n)
		integ_strobe |-> state == cic_pkg::ST_IDLE);

	// one output per pass
	a_out_single: assert property (@(posedge clock) disable iff (!rst_n)
		out_strobe |=> !out_strobe);

endmodule

// ==== design/cic_decimator.sv ====
`timescale 1ns/1ps

// CIC decimator top
// integrators at input rate, sequential comb at output rate
module cic_decimator (
	input logic clock,
	input logic rst_n,
	input cic_pkg::dec_t decimation,
	input logic in_strobe,
	input cic_pkg::sample_t in_data,
	output logic out_strobe,
	output cic_pkg::out_t out_data
);

	// decimated integrator output
	logic integ_strobe;
	cic_pkg::acc_t integ_data;

	// comb RAM ports
	cic_ram_if ram_bus ();

	// ------------------------------
	// integrators and counter
	// ------------------------------

	cic_integ_chain i_integ_chain (
		.clock(clock),
		.rst_n(rst_n),
		.decimation(decimation),
		.in_strobe(in_strobe),
		.in_data(in_data),
		.integ_strobe(integ_strobe),
		.integ_data(integ_data)
	);

	// ------------------------------
	// comb engine and its RAM
	// ------------------------------

	cic_comb_seq i_comb_seq (
		.clock(clock),
		.rst_n(rst_n),
		.integ_strobe(integ_strobe),
		.integ_data(integ_data),
		.ram(ram_bus.engine),
		.out_strobe(out_strobe),
		.out_data(out_data)
	);

	cic_comb_ram i_comb_ram (
		.clock(clock),
		.ram(ram_bus.ram)
	);

endmodule

// ==== design/cic_defines.svh ====
`ifndef CIC_DEFINES_SVH
`define CIC_DEFINES_SVH

// integrator and comb stage count
`define CIC_STAGES 5

// input sample width
`define CIC_IN_WIDTH 16

// worst case bit growth, 5 stages times log2(4096)
`define CIC_GROWTH 60

// accumulator width, 76 bits
`define CIC_ACC_WIDTH (`CIC_IN_WIDTH + `CIC_GROWTH)

// rounded output width
`define CIC_OUT_WIDTH 16

// decimation ratio, up to 4096
`define CIC_DEC_WIDTH 13

// stage index width, also covers the tail step
`define CIC_STAGE_WIDTH 3

// bank bit + kind bit + stage index
`define CIC_ADDR_WIDTH (`CIC_STAGE_WIDTH + 2)

`endif

// ==== design/cic_integ_chain.sv ====
`timescale 1ns/1ps
`include "cic_defines.svh"

module cic_integ_chain (
	input logic clock,
	input logic rst_n,
	input cic_pkg::dec_t decimation,
	input logic in_strobe,
	input cic_pkg::sample_t in_data,
	output logic integ_strobe,
	output cic_pkg::acc_t integ_data
);

	// integrator registers and their inputs
	cic_pkg::acc_t acc [`CIC_STAGES];
	cic_pkg::acc_t feed [`CIC_STAGES];

	// input samples seen in the current decimation period
	cic_pkg::dec_t sample_no;

	// ------------------------------
	// integrators
	// ------------------------------

	// sign extended input into the first stage
	assign feed[0] = cic_pkg::acc_t'(in_data);

	for (genvar i = 0; i < `CIC_STAGES; i++)
	begin : g_integ
		// stage i sums the previous register of stage i-1
		if (i > 0)
		begin : g_link
			assign feed[i] = acc[i-1];
		end

		// wraps freely, the comb differences undo it
		always_ff @(posedge clock)
		begin
			if (!rst_n)
				acc[i] <= '0;
			else if (in_strobe)
				acc[i] <= acc[i] + feed[i];
		end
	end

	assign integ_data = acc[`CIC_STAGES-1];

	// ------------------------------
	// decimation counter
	// ------------------------------

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			sample_no <= '0;
			integ_strobe <= 1'b0;
		end
		else
		begin
			integ_strobe <= 1'b0;
			if (in_strobe)
			begin
				// R-th sample, last integrator updates on this same edge
				if (sample_no == decimation - cic_pkg::dec_t'(1))
				begin
					sample_no <= '0;
					integ_strobe <= 1'b1;
				end
				else
					sample_no <= sample_no + cic_pkg::dec_t'(1);
			end
		end
	end

	// comb pass must finish before the next decimated sample
	a_min_decimation: assert property (@(posedge clock) disable iff (!rst_n)
		in_strobe |-> decimation >= cic_pkg::dec_t'(3 * `CIC_STAGES + 5));

endmodule

// ==== design/cic_pkg.sv ====
`include "cic_defines.svh"

package cic_pkg;

	// sample widths
	typedef logic signed [`CIC_IN_WIDTH-1:0] sample_t;
	typedef logic signed [`CIC_ACC_WIDTH-1:0] acc_t;
	typedef logic signed [`CIC_OUT_WIDTH-1:0] out_t;

	// control widths
	typedef logic [`CIC_DEC_WIDTH-1:0] dec_t;
	typedef logic [`CIC_STAGE_WIDTH-1:0] stage_t;

	// {bank, kind, stage}
	typedef logic [`CIC_ADDR_WIDTH-1:0] ram_addr_t;

	// comb engine states
	typedef enum logic [2:0] {
		ST_CLEAR,
		ST_IDLE,
		ST_LOAD,
		ST_DIFF,
		ST_SAVE,
		ST_TAIL,
		ST_OUT
	} comb_state_t;

endpackage

// ==== design/cic_ram_if.sv ====
`timescale 1ns/1ps

// comb RAM port bundle
// write side and read address come from the engine, read data from the RAM
interface cic_ram_if;

	// write port
	cic_pkg::ram_addr_t waddr;
	cic_pkg::acc_t wdata;
	logic wen;

	// read port, data one clock after address
	cic_pkg::ram_addr_t raddr;
	cic_pkg::acc_t rdata;

	modport engine (
		output waddr,
		output wdata,
		output wen,
		output raddr,
		input rdata
	);

	modport ram (
		input waddr,
		input wdata,
		input wen,
		input raddr,
		output rdata
	);

endinterface

// ==== testbench/tb_cic_decimator.sv ====
`timescale 1ns/1ps
`include "cic_defines.svh"

module tb_cic_decimator;

	localparam int CLK_HALF = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 8;
	// completing in_strobe to out_strobe
	localparam int LATENCY = 3 * `CIC_STAGES + 4;
	localparam int DRAIN_TIMEOUT = 4 * LATENCY;

	logic clock;
	logic rst_n;
	cic_pkg::dec_t decimation;
	logic in_strobe;
	cic_pkg::sample_t in_data;
	logic out_strobe;
	cic_pkg::out_t out_data;

	// software CIC state
	cic_pkg::acc_t integ_m [`CIC_STAGES];
	cic_pkg::acc_t prev_m [`CIC_STAGES+1];
	int count_m;
	int ratio;
	cic_pkg::out_t expected [$];

	// bookkeeping per scenario
	int inputs_sent;
	int outputs_seen;
	int out_base;

	cic_decimator i_cic_decimator (
		.clock(clock),
		.rst_n(rst_n),
		.decimation(decimation),
		.in_strobe(in_strobe),
		.in_data(in_data),
		.out_strobe(out_strobe),
		.out_data(out_data)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#CLK_HALF clock = ~clock;
	end

	// ------------------------------
	// failure and compare helpers
	// ------------------------------

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_sample(input cic_pkg::out_t got, input cic_pkg::out_t exp,
		input string what);
		if (got !== exp)
			stop_failed($sformatf("ERR %0t ns: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			stop_failed($sformatf("ERR %0t ns: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	// ------------------------------
	// reference model
	// ------------------------------

	// round half up on the top output bits
	// result wraps like the output word
	function automatic cic_pkg::out_t round_output(input cic_pkg::acc_t c);
		cic_pkg::acc_t half;
		cic_pkg::acc_t r;
		half = cic_pkg::acc_t'(1) <<< (`CIC_ACC_WIDTH - `CIC_OUT_WIDTH - 1);
		r = (c + half) >>> (`CIC_ACC_WIDTH - `CIC_OUT_WIDTH);
		return cic_pkg::out_t'(r);
	endfunction

	task automatic clear_model();
		for (int i = 0; i < `CIC_STAGES; i++)
			integ_m[i] = '0;
		for (int i = 0; i <= `CIC_STAGES; i++)
			prev_m[i] = '0;
		count_m = 0;
		expected.delete();
	endtask

	task automatic step_model(input cic_pkg::sample_t x);
		cic_pkg::acc_t c;
		cic_pkg::acc_t d;
		// integrator registers all move on one edge
		// each takes the old value of the stage below
		for (int i = `CIC_STAGES - 1; i > 0; i--)
			integ_m[i] = integ_m[i] + integ_m[i-1];
		integ_m[0] = integ_m[0] + cic_pkg::acc_t'(x);
		count_m++;
		if (count_m == ratio)
		begin
			count_m = 0;
			// comb cascade with differential delay 1
			c = integ_m[`CIC_STAGES-1];
			for (int i = 1; i <= `CIC_STAGES; i++)
			begin
				d = c - prev_m[i];
				prev_m[i] = c;
				c = d;
			end
			expected.push_back(round_output(c));
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	task automatic next_cycle();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			next_cycle();
	endtask

	// R only changes while reset is held
	task automatic apply_reset(input int r);
		rst_n = 1'b0;
		in_strobe = 1'b0;
		in_data = '0;
		decimation = cic_pkg::dec_t'(r);
		ratio = r;
		clear_model();
		inputs_sent = 0;
		out_base = outputs_seen;
		idle_cycles(RESET_CYCLES);
		rst_n = 1'b1;
	endtask

	task automatic drive_sample(input cic_pkg::sample_t x);
		in_strobe = 1'b1;
		in_data = x;
		step_model(x);
		inputs_sent++;
		next_cycle();
		in_strobe = 1'b0;
	endtask

	// wait for the last pass and then a quiet period for stray pulses
	task automatic finish_scenario(input string name);
		int waited;
		int wanted;
		waited = 0;
		// one output per R inputs, rounded down
		wanted = inputs_sent / ratio;
		while (outputs_seen - out_base < wanted)
		begin
			if (waited == DRAIN_TIMEOUT)
				stop_failed($sformatf("timed out waiting for outputs in %s", name));
			else
			begin
				next_cycle();
				waited++;
			end
		end
		idle_cycles(LATENCY);
		check_count(outputs_seen - out_base, wanted, {name, " output count"});
	endtask

	// monitor samples at the falling edge where outputs are settled
	always @(negedge clock)
	begin
		if (rst_n && out_strobe)
		begin
			outputs_seen++;
			if (expected.size() != 0)
				check_sample(out_data, expected.pop_front(), "output sample");
		end
	end

	// ------------------------------
	// scenarios
	// ------------------------------

	initial
	begin
		void'($urandom(15));
		rst_n = 1'b0;
		in_strobe = 1'b0;
		in_data = '0;
		decimation = cic_pkg::dec_t'(32);
		ratio = 32;
		outputs_seen = 0;
		out_base = 0;
		inputs_sent = 0;
		clear_model();
		next_cycle();

		// step response at full positive scale
		apply_reset(32);
		for (int n = 0; n < 12 * 32; n++)
			drive_sample(cic_pkg::sample_t'(16'h7fff));
		finish_scenario("step");

		// back to back passes at minimum R
		apply_reset(20);
		for (int n = 0; n < 20 * 20 + 7; n++)
			drive_sample(cic_pkg::sample_t'($urandom));
		finish_scenario("random dense");

		// gaps between input strobes
		apply_reset(64);
		for (int n = 0; n < 700; n++)
		begin
			drive_sample(cic_pkg::sample_t'($urandom));
			idle_cycles($urandom_range(0, 3));
		end
		finish_scenario("random gaps");

		// largest R with negative full scale
		apply_reset(4096);
		for (int n = 0; n < 4 * 4096; n++)
			drive_sample(cic_pkg::sample_t'(16'h8000));
		finish_scenario("max growth");

		// run part of a period and reset under way
		for (int n = 0; n < 1000; n++)
			drive_sample(cic_pkg::sample_t'($urandom));
		apply_reset(100);
		for (int n = 0; n < 530; n++)
			drive_sample(cic_pkg::sample_t'($urandom));
		finish_scenario("reset mid run");

		$display("TEST OK");
		$finish;
	end

endmodule
